// ==== Bender.yml ====
package:
  name: raster

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/raster_pkg.sv
      - verilog/tile_fifo.sv
      - verilog/coverage_mask.sv
      - verilog/tile_walker.sv
      - verilog/triangle_setup.sv
      - verilog/raster_regs.sv
      - verilog/raster_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/raster_sva.sv
      - bench/raster_tb.sv

// ==== bench/raster_stimulus.txt ====
# tri name x1 y1 x2 y2 x3 y3 clip_en left top right bottom mode tiles
# mode 1 slow reads, mode 2 second start; tile lines: tile tile_x tile_y mask_hex
tri one_tile 8 4 12 4 8 8 0 0 0 0 0 0 1
tile 8 4 0260
tri big_slow 0 0 16 0 0 16 0 0 0 0 0 1 10
tile 0 0 eee0
tile 4 0 fff0
tile 8 0 fff0
tile 12 0 1370
tile 0 4 eeee
tile 4 4 ffff
tile 8 4 137f
tile 0 8 eeee
tile 4 8 137f
tile 0 12 026e
tri clipped 0 0 16 0 0 16 1 5 3 10 9 0 5
tile 4 0 fff0
tile 8 0 fff0
tile 4 4 ffff
tile 8 4 137f
tile 4 8 137f
tri restart -8 20 8 20 -8 36 0 0 0 0 0 2 10
tile -8 20 eee0
tile -4 20 fff0
tile 0 20 fff0
tile 4 20 1370
tile -8 24 eeee
tile -4 24 ffff
tile 0 24 137f
tile -8 28 eeee
tile -4 28 137f
tile -8 32 026e

// ==== bench/raster_sva.sv ====
`timescale 1ns/10ps

module raster_sva (
    input logic       clk,
    input logic       reset,
    input logic       s_awvalid,
    input logic       s_awready,
    input logic       s_wvalid,
    input logic       s_wready,
    input logic       s_bvalid,
    input logic       s_bready,
    input logic       s_arvalid,
    input logic       s_arready,
    input logic       s_rvalid,
    input logic       s_rready,
    input logic       push,
    input logic       pop,
    input logic [3:0] fifo_count
);

    int fail_count = 0;

    // valids hold until the matching ready
    aw_hold: assert property (@(posedge clk) disable iff (reset)
        s_awvalid && !s_awready |=> s_awvalid)
        else begin
            fail_count++;
            $error("awvalid dropped before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (reset)
        s_wvalid && !s_wready |=> s_wvalid)
        else begin
            fail_count++;
            $error("wvalid dropped before wready");
        end

    b_hold: assert property (@(posedge clk) disable iff (reset)
        s_bvalid && !s_bready |=> s_bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        s_arvalid && !s_arready |=> s_arvalid)
        else begin
            fail_count++;
            $error("arvalid dropped before arready");
        end

    r_hold: assert property (@(posedge clk) disable iff (reset)
        s_rvalid && !s_rready |=> s_rvalid)
        else begin
            fail_count++;
            $error("rvalid dropped before rready");
        end

    // a push on a full FIFO or a pop on an empty one leaves the count unmoved
    push_counted: assert property (@(posedge clk) disable iff (reset)
        push && !pop |=> fifo_count == $past(fifo_count) + 4'd1)
        else begin
            fail_count++;
            $error("walker pushed into a full FIFO");
        end

    pop_counted: assert property (@(posedge clk) disable iff (reset)
        pop && !push |=> fifo_count == $past(fifo_count) - 4'd1)
        else begin
            fail_count++;
            $error("pop issued on an empty FIFO");
        end

endmodule

// ==== bench/raster_tb.sv ====
`timescale 1ns/10ps
`include "raster_defines.svh"

module raster_tb;
    import raster_pkg::*;

    localparam int timeout_cycles = 200;
    localparam int poll_limit = 400; // status reads
    localparam int fifo_depth = `RASTER_FIFO_DEPTH;
    localparam int until_avail = 0;
    localparam int until_full = 1;
    localparam int until_idle = 2;

    logic clk = 1'b0;
    logic reset;
    logic [31:0] s_awaddr;
    logic s_awvalid;
    logic s_awready;
    logic [31:0] s_wdata;
    logic s_wvalid;
    logic s_wready;
    logic [1:0] s_bresp;
    logic s_bvalid;
    logic s_bready;
    logic [31:0] s_araddr;
    logic s_arvalid;
    logic s_arready;
    logic [31:0] s_rdata;
    logic [1:0] s_rresp;
    logic s_rvalid;
    logic s_rready;

    int cfg [10]; // x1 y1 x2 y2 x3 y3, then clip left top right bottom
    tile_t expected_tiles [$];
    int unsigned rand_state = 32'd24409;

    raster_top raster_top_inst (
        .clk(clk), .reset(reset),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready)
    );

    bind raster_top raster_sva raster_sva_inst (
        .clk(clk), .reset(reset),
        .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rvalid(s_rvalid), .s_rready(s_rready),
        .push(push), .pop(pop), .fifo_count(fifo_count)
    );

    always #5 clk = ~clk;

    // stop at the first protocol assertion that fires
    always @(raster_top_inst.raster_sva_inst.fail_count) begin
        if (raster_top_inst.raster_sva_inst.fail_count != 0) begin
            abort_run("protocol assertion failed");
        end
    end

    function automatic int unsigned next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 24;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_resp(input string test, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected resp=%0d, actual resp=%0d", test, expected, actual);
            abort_run("AXI response not OKAY");
        end
    endtask

    task automatic axi_write(input logic [3:0] idx, input logic [31:0] data);
        int cycles;
        @(posedge clk);
        #1;
        s_awaddr = {26'd0, idx, 2'b00};
        s_wdata = data;
        s_awvalid = 1'b1;
        s_wvalid = 1'b1;
        cycles = 0;
        while (!(s_awready && s_wready)) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) abort_run($sformatf("write to word %0d never accepted", idx));
        end
        @(posedge clk); // address and data transfer here
        #1;
        s_awvalid = 1'b0;
        s_wvalid = 1'b0;
        s_bready = 1'b1;
        cycles = 0;
        while (!s_bvalid) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) abort_run($sformatf("no write response for word %0d", idx));
        end
        check_resp($sformatf("write word %0d", idx), 2'b00, s_bresp);
        @(posedge clk);
        #1;
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] idx, output logic [31:0] data, input bit slow);
        int cycles;
        int unsigned pause;
        @(posedge clk);
        #1;
        s_araddr = {26'd0, idx, 2'b00};
        s_arvalid = 1'b1;
        cycles = 0;
        while (!s_arready) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) abort_run($sformatf("read of word %0d never accepted", idx));
        end
        @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        pause = slow ? next_random() % 5 : 0; // hold off rready
        repeat (pause) begin
            @(posedge clk);
            #1;
        end
        cycles = 0;
        while (!s_rvalid) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) abort_run($sformatf("no read data for word %0d", idx));
        end
        data = s_rdata;
        check_resp($sformatf("read word %0d", idx), 2'b00, s_rresp);
        s_rready = 1'b1;
        @(posedge clk);
        #1;
        s_rready = 1'b0;
    endtask

    task automatic check_tile(input string test, input tile_t expected, input tile_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected x=%0d y=%0d mask=%h, actual x=%0d y=%0d mask=%h",
                     test, expected.tile_x, expected.tile_y, expected.mask,
                     actual.tile_x, actual.tile_y, actual.mask);
            abort_run("tile readout mismatch");
        end
    endtask

    task automatic check_status(input string test, input logic busy, input logic [3:0] count,
                                input logic [31:0] word);
        if (word[`RASTER_STAT_BUSY] !== busy || word[`RASTER_STAT_COUNT +: 4] !== count) begin
            $display("[ERROR] %s: expected busy=%0b count=%0d, actual busy=%0b count=%0d",
                     test, busy, count, word[`RASTER_STAT_BUSY], word[`RASTER_STAT_COUNT +: 4]);
            abort_run("status mismatch");
        end
    endtask

    task automatic poll_status(input string test, input int kind);
        logic [31:0] word;
        logic done;
        int polls;
        polls = 0;
        done = 1'b0;
        while (!done) begin
            axi_read(`RASTER_REG_STATUS, word, 1'b0);
            case (kind)
                until_avail: done = word[`RASTER_STAT_AVAIL];
                until_full: done = word[`RASTER_STAT_COUNT +: 4] == 4'(fifo_depth);
                default: done = !word[`RASTER_STAT_BUSY];
            endcase
            polls++;
            if (!done && polls > poll_limit) begin
                abort_run($sformatf("%s: status never reached the awaited state %0d", test, kind));
            end
        end
    endtask

    task automatic run_triangle(input string test, input logic clip_en, input int mode);
        logic [31:0] word;
        tile_t actual;
        for (int i = 0; i < 10; i++) begin
            axi_write(4'(i), 32'(cfg[i]));
        end
        axi_write(`RASTER_REG_CONTROL, {30'd0, clip_en, 1'b1});
        if (mode == 2) begin
            poll_status(test, until_full); // walker now stalled
            axi_write(`RASTER_REG_X1, 32'd100);
            axi_write(`RASTER_REG_CONTROL, 32'd1);
            axi_read(`RASTER_REG_STATUS, word, 1'b0);
            check_status({test, " second start"}, 1'b1, 4'(fifo_depth), word);
        end
        foreach (expected_tiles[j]) begin
            poll_status(test, until_avail);
            if (mode == 1) repeat (next_random() % 8) @(posedge clk);
            axi_read(`RASTER_REG_TILE_POS, word, mode == 1);
            actual.tile_x = word[15:0];
            actual.tile_y = word[31:16];
            axi_read(`RASTER_REG_TILE_MASK, word, mode == 1); // pops
            actual.mask = word[15:0];
            check_tile($sformatf("%s tile %0d", test, j), expected_tiles[j], actual);
        end
        poll_status(test, until_idle);
        axi_read(`RASTER_REG_STATUS, word, 1'b0);
        check_status({test, " end"}, 1'b0, 4'd0, word); // no extra tiles left
    endtask

    initial begin : main
        int fd;
        int rc;
        int tests;
        int n;
        int tx;
        int ty;
        int clip_en;
        int mode;
        logic [15:0] m;
        logic [8*24-1:0] kw;
        logic [8*24-1:0] name;
        logic [8*160-1:0] rest;
        logic [31:0] word;
        tile_t actual;
        tile_t expected;
        reset = 1'b1;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // idle engine, empty FIFO
        axi_read(`RASTER_REG_STATUS, word, 1'b0);
        check_status("after_reset status", 1'b0, 4'd0, word);
        axi_read(`RASTER_REG_TILE_POS, word, 1'b0);
        actual.tile_x = word[15:0];
        actual.tile_y = word[31:16];
        axi_read(`RASTER_REG_TILE_MASK, word, 1'b0);
        actual.mask = word[15:0];
        check_tile("after_reset readout", '0, actual);

        fd = $fopen("bench/raster_stimulus.txt", "r");
        if (fd == 0) abort_run("could not open bench/raster_stimulus.txt");
        tests = 0;
        while ($fscanf(fd, "%s", kw) == 1) begin
            if (kw == "#") begin
                rc = $fgets(rest, fd);
            end else if (kw == "tri") begin
                rc = $fscanf(fd, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
                             cfg[0], cfg[1], cfg[2], cfg[3], cfg[4], cfg[5],
                             clip_en, cfg[6], cfg[7], cfg[8], cfg[9], mode, n);
                if (rc != 14) abort_run("malformed triangle line in stimulus file");
                expected_tiles.delete();
                for (int j = 0; j < n; j++) begin
                    rc = $fscanf(fd, "%s %d %d %h", kw, tx, ty, m);
                    if (rc != 4 || kw != "tile") abort_run("malformed tile line in stimulus file");
                    expected.tile_x = coord_t'(tx);
                    expected.tile_y = coord_t'(ty);
                    expected.mask = m;
                    expected_tiles.push_back(expected);
                end
                run_triangle(string'(name), clip_en[0], mode);
                tests++;
            end else begin
                abort_run("unknown line in stimulus file");
            end
        end
        $fclose(fd);
        if (tests == 0) abort_run("stimulus file holds no triangles");
        if (raster_top_inst.raster_sva_inst.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("protocol assertions fired during the run");
        end
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/raster_pkg.sv
verilog/tile_fifo.sv
verilog/coverage_mask.sv
verilog/tile_walker.sv
verilog/triangle_setup.sv
verilog/raster_regs.sv
verilog/raster_top.sv
bench/raster_sva.sv
bench/raster_tb.sv

// ==== verilog/coverage_mask.sv ====
`timescale 1ns/10ps
`include "raster_defines.svh"

module coverage_mask (
    input  raster_pkg::edge_t [2:0] edges,
    input  raster_pkg::coord_t      tile_x,
    input  raster_pkg::coord_t      tile_y,
    output logic [15:0]             mask
);

    localparam int ts = `RASTER_TILE_SIZE;

    always_comb begin : eval
        logic signed [16:0] px; // one extra bit for the tile offset
        logic signed [16:0] py;
        logic signed [47:0] val;
        logic covered;
        for (int i = 0; i < ts * ts; i++) begin
            px = 17'(tile_x) + 17'(i % ts);
            py = 17'(tile_y) + 17'(i / ts);
            covered = 1'b1;
            for (int k = 0; k < 3; k++) begin
                val = edges[k].a * px + edges[k].b * py + edges[k].c;
                covered = covered && val[47]; // strictly negative
            end
            mask[i] = covered;
        end
    end

endmodule

// ==== verilog/raster_defines.svh ====
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

`define RASTER_TILE_SIZE 4
`define RASTER_FIFO_DEPTH 8

// write side word indices
`define RASTER_REG_X1 4'd0
`define RASTER_REG_Y1 4'd1
`define RASTER_REG_X2 4'd2
`define RASTER_REG_Y2 4'd3
`define RASTER_REG_X3 4'd4
`define RASTER_REG_Y3 4'd5
`define RASTER_REG_CLIP_LEFT 4'd6
`define RASTER_REG_CLIP_TOP 4'd7
`define RASTER_REG_CLIP_RIGHT 4'd8
`define RASTER_REG_CLIP_BOT 4'd9
`define RASTER_REG_CONTROL 4'd10

`define RASTER_CTRL_START 0
`define RASTER_CTRL_CLIP_EN 1

// read side word indices
`define RASTER_REG_STATUS 4'd0
`define RASTER_REG_TILE_POS 4'd1
`define RASTER_REG_TILE_MASK 4'd2

`define RASTER_STAT_BUSY 0
`define RASTER_STAT_AVAIL 1
`define RASTER_STAT_COUNT 8

`endif

// ==== verilog/raster_pkg.sv ====
package raster_pkg;

    // integer pixel coordinate
    typedef logic signed [15:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // value at a pixel is a*x + b*y + c
    typedef struct packed {
        logic signed [31:0] a;
        logic signed [31:0] b;
        logic signed [47:0] c;
    } edge_t;

    // inclusive bounds
    typedef struct packed {
        coord_t min_x;
        coord_t min_y;
        coord_t max_x;
        coord_t max_y;
    } bbox_t;

    typedef struct packed {
        coord_t tile_x;
        coord_t tile_y;
        logic [15:0] mask; // bit i at (i mod 4, i div 4)
    } tile_t;

endpackage

// ==== verilog/raster_regs.sv ====
`timescale 1ns/10ps
`include "raster_defines.svh"

module raster_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic [31:0]         s_awaddr,
    input  logic                s_awvalid,
    output logic                s_awready,
    input  logic [31:0]         s_wdata,
    input  logic                s_wvalid,
    output logic                s_wready,
    output logic [1:0]          s_bresp,
    output logic                s_bvalid,
    input  logic                s_bready,
    input  logic [31:0]         s_araddr,
    input  logic                s_arvalid,
    output logic                s_arready,
    output logic [31:0]         s_rdata,
    output logic [1:0]          s_rresp,
    output logic                s_rvalid,
    input  logic                s_rready,
    output raster_pkg::vertex_t v1,
    output raster_pkg::vertex_t v2,
    output raster_pkg::vertex_t v3,
    output raster_pkg::bbox_t   clip,
    output logic                clip_en,
    output logic                start,
    input  logic                engine_busy,
    input  raster_pkg::tile_t   head,
    input  logic                fifo_empty,
    input  logic [3:0]          fifo_count,
    output logic                pop
);

    logic [3:0] wr_idx;
    logic [3:0] rd_idx;
    logic wr_en;
    logic rd_en;
    logic [1:0] setup_pipe; // start travelling through the two setup stages
    logic busy;
    logic [31:0] rd_word;

    assign wr_idx = s_awaddr[5:2];
    assign rd_idx = s_araddr[5:2];
    assign wr_en = s_awready && s_awvalid && s_wvalid;
    assign rd_en = s_arready && s_arvalid;
    assign busy = start || (setup_pipe != 2'b00) || engine_busy;
    assign pop = rd_en && (rd_idx == `RASTER_REG_TILE_MASK) && !fifo_empty;
    assign s_bresp = 2'b00; // always OKAY
    assign s_rresp = 2'b00;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_awready <= 1'b0;
            s_wready <= 1'b0;
            s_bvalid <= 1'b0;
            start <= 1'b0;
            clip_en <= 1'b0;
            setup_pipe <= 2'b00;
        end else begin
            // accept address and data together, one cycle
            s_awready <= !s_awready && !s_bvalid && s_awvalid && s_wvalid;
            s_wready <= !s_awready && !s_bvalid && s_awvalid && s_wvalid;
            start <= wr_en && (wr_idx == `RASTER_REG_CONTROL) &&
                     s_wdata[`RASTER_CTRL_START] && !busy;
            setup_pipe <= {setup_pipe[0], start};
            if (wr_en) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
            if (wr_en && (wr_idx == `RASTER_REG_CONTROL)) begin
                clip_en <= s_wdata[`RASTER_CTRL_CLIP_EN];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_idx)
                `RASTER_REG_X1: v1.x <= s_wdata[15:0];
                `RASTER_REG_Y1: v1.y <= s_wdata[15:0];
                `RASTER_REG_X2: v2.x <= s_wdata[15:0];
                `RASTER_REG_Y2: v2.y <= s_wdata[15:0];
                `RASTER_REG_X3: v3.x <= s_wdata[15:0];
                `RASTER_REG_Y3: v3.y <= s_wdata[15:0];
                `RASTER_REG_CLIP_LEFT: clip.min_x <= s_wdata[15:0];
                `RASTER_REG_CLIP_TOP: clip.min_y <= s_wdata[15:0];
                `RASTER_REG_CLIP_RIGHT: clip.max_x <= s_wdata[15:0];
                `RASTER_REG_CLIP_BOT: clip.max_y <= s_wdata[15:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_word = '0;
        case (rd_idx)
            `RASTER_REG_STATUS: begin
                rd_word[`RASTER_STAT_BUSY] = busy;
                rd_word[`RASTER_STAT_AVAIL] = !fifo_empty;
                rd_word[`RASTER_STAT_COUNT +: 4] = fifo_count;
            end
            `RASTER_REG_TILE_POS: begin
                if (!fifo_empty) rd_word = {head.tile_y, head.tile_x};
            end
            `RASTER_REG_TILE_MASK: begin
                if (!fifo_empty) rd_word[15:0] = head.mask;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_arready <= 1'b0;
            s_rvalid <= 1'b0;
        end else begin
            s_arready <= !s_arready && !s_rvalid && s_arvalid;
            if (rd_en) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) s_rdata <= rd_word; // captured with the pop
    end

endmodule

// ==== verilog/raster_top.sv ====
`timescale 1ns/10ps

module raster_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [31:0] s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready
);
    import raster_pkg::*;

    vertex_t v1;
    vertex_t v2;
    vertex_t v3;
    bbox_t clip;
    bbox_t box;
    edge_t [2:0] edges;
    tile_t tile;
    tile_t head;
    logic clip_en;
    logic start;
    logic setup_done;
    logic walker_busy;
    logic push;
    logic pop;
    logic fifo_full;
    logic fifo_empty;
    logic [3:0] fifo_count;

    raster_regs raster_regs_inst (
        .clk(clk), .reset(reset),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .v1(v1), .v2(v2), .v3(v3), .clip(clip), .clip_en(clip_en), .start(start),
        .engine_busy(walker_busy), // setup activity is tracked inside the register block
        .head(head), .fifo_empty(fifo_empty), .fifo_count(fifo_count), .pop(pop)
    );

    triangle_setup triangle_setup_inst (
        .clk(clk), .reset(reset),
        .v1(v1), .v2(v2), .v3(v3), .clip(clip), .clip_en(clip_en), .start(start),
        .edges(edges), .box(box), .setup_done(setup_done)
    );

    tile_walker tile_walker_inst (
        .clk(clk), .reset(reset),
        .edges(edges), .box(box), .setup_done(setup_done), .fifo_full(fifo_full),
        .push(push), .tile(tile), .walker_busy(walker_busy)
    );

    tile_fifo #(.item_t(tile_t)) tile_fifo_inst (
        .clk(clk), .reset(reset),
        .push(push), .push_data(tile), .pop(pop),
        .head(head), .full(fifo_full), .empty(fifo_empty), .count(fifo_count)
    );

endmodule

// ==== verilog/tile_fifo.sv ====
`timescale 1ns/10ps
`include "raster_defines.svh"

module tile_fifo #(
    parameter type item_t = logic [31:0],
    parameter int depth = `RASTER_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  item_t                  push_data,
    input  logic                   pop,
    output item_t                  head,
    output logic                   full,
    output logic                   empty,
    output logic [$clog2(depth):0] count
);

    localparam int ptr_w = $clog2(depth);

    item_t mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    assign full = count == depth;
    assign empty = count == '0;
    assign do_pop = pop && !empty;
    assign do_push = push && (!full || do_pop); // full plus pop frees a slot
    assign head = mem[rd_ptr]; // fall-through head

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== verilog/tile_walker.sv ====
`timescale 1ns/10ps
`include "raster_defines.svh"

module tile_walker (
    input  logic                    clk,
    input  logic                    reset,
    input  raster_pkg::edge_t [2:0] edges,
    input  raster_pkg::bbox_t       box,
    input  logic                    setup_done,
    input  logic                    fifo_full,
    output logic                    push,
    output raster_pkg::tile_t       tile,
    output logic                    walker_busy
);
    import raster_pkg::*;

    localparam coord_t step = coord_t'(`RASTER_TILE_SIZE);

    coord_t tile_x;
    coord_t tile_y;
    coord_t row_start; // rounded min_x
    logic [15:0] mask;
    logic in_x;
    logic in_y;
    logic hit;

    // floor to a tile boundary, also for negative values
    function automatic coord_t align(coord_t v);
        return v & ~(step - coord_t'(1));
    endfunction

    coverage_mask coverage_mask_inst (
        .edges(edges),
        .tile_x(tile_x),
        .tile_y(tile_y),
        .mask(mask)
    );

    assign in_x = tile_x <= box.max_x;
    assign in_y = tile_y <= box.max_y;
    assign hit = walker_busy && in_y && in_x && (mask != '0);
    assign push = hit && !fifo_full;

    assign tile.tile_x = tile_x;
    assign tile.tile_y = tile_y;
    assign tile.mask = mask;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            walker_busy <= 1'b0;
            tile_x <= '0;
            tile_y <= '0;
            row_start <= '0;
        end else if (setup_done) begin
            walker_busy <= 1'b1;
            tile_x <= align(box.min_x);
            tile_y <= align(box.min_y);
            row_start <= align(box.min_x);
        end else if (walker_busy) begin
            if (!in_y) begin
                walker_busy <= 1'b0; // past the last row
            end else if (!in_x) begin
                tile_x <= row_start;
                tile_y <= tile_y + step;
            end else if (!(hit && fifo_full)) begin
                tile_x <= tile_x + step; // empty tiles skip straight on
            end
        end
    end

endmodule

// ==== verilog/triangle_setup.sv ====
`timescale 1ns/10ps

module triangle_setup (
    input  logic                    clk,
    input  logic                    reset,
    input  raster_pkg::vertex_t     v1,
    input  raster_pkg::vertex_t     v2,
    input  raster_pkg::vertex_t     v3,
    input  raster_pkg::bbox_t       clip,
    input  logic                    clip_en,
    input  logic                    start,
    output raster_pkg::edge_t [2:0] edges,
    output raster_pkg::bbox_t       box,
    output logic                    setup_done
);
    import raster_pkg::*;

    vertex_t vin [3];
    vertex_t vtx [3];
    logic signed [31:0] s1_a [3];
    logic signed [31:0] s1_b [3];
    bbox_t vbox; // unclipped vertex box
    bbox_t clip_q;
    logic clip_en_q;
    logic s1_valid;

    function automatic coord_t min3(coord_t p, coord_t q, coord_t r);
        coord_t m;
        m = (p < q) ? p : q;
        return (m < r) ? m : r;
    endfunction

    function automatic coord_t max3(coord_t p, coord_t q, coord_t r);
        coord_t m;
        m = (p > q) ? p : q;
        return (m > r) ? m : r;
    endfunction

    assign vin = '{v1, v2, v3};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            setup_done <= 1'b0;
        end else begin
            s1_valid <= start;
            setup_done <= s1_valid;
        end
    end

    // stage 1: differences and vertex extents
    always_ff @(posedge clk) begin
        if (start) begin
            for (int k = 0; k < 3; k++) begin
                vtx[k] <= vin[k];
                s1_a[k] <= 32'(vin[(k + 1) % 3].y) - 32'(vin[k].y);
                s1_b[k] <= 32'(vin[k].x) - 32'(vin[(k + 1) % 3].x);
            end
            vbox.min_x <= min3(v1.x, v2.x, v3.x);
            vbox.min_y <= min3(v1.y, v2.y, v3.y);
            vbox.max_x <= max3(v1.x, v2.x, v3.x);
            vbox.max_y <= max3(v1.y, v2.y, v3.y);
            clip_q <= clip;
            clip_en_q <= clip_en;
        end
    end

    // stage 2: c products and the clipped box
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int k = 0; k < 3; k++) begin
                edges[k].a <= s1_a[k];
                edges[k].b <= s1_b[k];
                edges[k].c <= 48'(vtx[(k + 1) % 3].x) * 48'(vtx[k].y) -
                              48'(vtx[k].x) * 48'(vtx[(k + 1) % 3].y);
            end
            box.min_x <= (clip_en_q && clip_q.min_x > vbox.min_x) ? clip_q.min_x : vbox.min_x;
            box.min_y <= (clip_en_q && clip_q.min_y > vbox.min_y) ? clip_q.min_y : vbox.min_y;
            box.max_x <= (clip_en_q && clip_q.max_x < vbox.max_x) ? clip_q.max_x : vbox.max_x;
            box.max_y <= (clip_en_q && clip_q.max_y < vbox.max_y) ? clip_q.max_y : vbox.max_y;
        end
    end

endmodule
